//--- common/robot_cfg.svh
`ifndef ROBOT_CFG_SVH
`define ROBOT_CFG_SVH

// Remote key codes, mode selection
`define KEY_CAM    8'h0f
`define KEY_IR     8'h13
`define KEY_IDLE   8'h10

// Remote key codes, drive commands
`define KEY_STOP   8'h0c
`define KEY_LEFT   8'h14
`define KEY_RIGHT  8'h18
`define KEY_SLOW   8'h01
`define KEY_MEDIUM 8'h02
`define KEY_FAST   8'h03

// Direction reported by the camera pipeline
`define CAM_DIR_LEFT  3'b001
`define CAM_DIR_RIGHT 3'b010
`define CAM_DIR_AHEAD 3'b011

`define KEY_FIFO_DEPTH 4     // Power of two
`define IR_FRAME_BITS  16    // Key byte then its complement

`endif

//--- common/robot_pkg.sv
package robot_pkg;

    // Top level operating mode
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        CAM  = 2'b01,
        IR   = 2'b10
    } op_mode_t;

    // Sub-state used while the camera steers
    typedef enum logic [1:0] {
        SEARCH = 2'b00,     // Turning until target seen
        FOLLOW = 2'b01,     // Target in view
        PAUSE  = 2'b11      // Camera steering inactive
    } cam_state_t;

    // Command handed to the motor stage
    typedef enum logic [2:0] {
        STOP   = 3'b000,
        LEFT   = 3'b001,
        RIGHT  = 3'b010,
        SLOW   = 3'b011,
        MEDIUM = 3'b100,
        FAST   = 3'b101
    } drive_state_t;

endpackage

//--- filelist.f
+incdir+common
common/robot_pkg.sv
source/ir_frame_rx.sv
source/key_fifo.sv
mode_fsm/mode_fsm.sv
mode_fsm/status_display.sv
source/robot_ctrl_top.sv
sim/robot_ctrl_tb.sv

//--- mode_fsm/mode_fsm.sv
`timescale 1ns/100ps
`include "robot_cfg.svh"

module mode_fsm
    import robot_pkg::*;
(
    input  logic         clk_50,
    input  logic         rst_n,
    input  logic [7:0]   key_head,
    input  logic         key_empty,
    input  logic [2:0]   cam_direction,
    input  logic [1:0]   cam_speed,
    input  logic         orange_detected,
    output logic         key_pop,
    output op_mode_t     op_mode,
    output cam_state_t   cam_state,
    output drive_state_t drive_state,
    output logic         mode_change
);

    op_mode_t     mode_next;
    cam_state_t   cam_next;
    drive_state_t drive_next;
    drive_state_t key_drive;
    logic         key_valid;
    logic         is_drive_key;

    assign key_valid = !key_empty;
    assign key_pop   = key_valid;   // Never stalls, one key per cycle

    // Mode moves only on a popped key
    always_comb begin
        mode_next = op_mode;
        if (key_valid) begin
            case (op_mode)
                IDLE:    mode_next = (key_head == `KEY_CAM) ? CAM :
                                     (key_head == `KEY_IR)  ? IR  : IDLE;
                CAM:     mode_next = (key_head == `KEY_IR)   ? IR   :
                                     (key_head == `KEY_IDLE) ? IDLE : CAM;
                IR:      mode_next = (key_head == `KEY_CAM)  ? CAM  :
                                     (key_head == `KEY_IDLE) ? IDLE : IR;
                default: mode_next = IDLE;
            endcase
        end
    end

    // Remote drive keys
    always_comb begin
        is_drive_key = key_valid;
        case (key_head)
            `KEY_STOP:   key_drive = STOP;
            `KEY_LEFT:   key_drive = LEFT;
            `KEY_RIGHT:  key_drive = RIGHT;
            `KEY_SLOW:   key_drive = SLOW;
            `KEY_MEDIUM: key_drive = MEDIUM;
            `KEY_FAST:   key_drive = FAST;
            default: begin
                key_drive    = STOP;
                is_drive_key = 1'b0;
            end
        endcase
    end

    // Camera sub-state follows the next mode
    always_comb begin
        if (mode_next != CAM) begin
            cam_next = PAUSE;
        end else if (cam_state == PAUSE) begin
            cam_next = SEARCH;                                   // Just entered CAM
        end else begin
            cam_next = orange_detected ? FOLLOW : SEARCH;
        end
    end

    always_comb begin
        drive_next = STOP;
        case (mode_next)
            CAM: begin
                if (cam_next == SEARCH) begin
                    drive_next = RIGHT;                          // Spin to look for target
                end else if (cam_direction == `CAM_DIR_LEFT) begin
                    drive_next = LEFT;
                end else if (cam_direction == `CAM_DIR_RIGHT) begin
                    drive_next = RIGHT;
                end else if (cam_direction == `CAM_DIR_AHEAD) begin
                    case (cam_speed)
                        2'd0:    drive_next = SLOW;
                        2'd1:    drive_next = MEDIUM;
                        2'd2:    drive_next = FAST;
                        default: drive_next = STOP;
                    endcase
                end
            end
            IR: begin
                if (op_mode != IR) begin
                    drive_next = STOP;                           // Entering remote control
                end else if (is_drive_key) begin
                    drive_next = key_drive;
                end else begin
                    drive_next = drive_state;                    // Hold last command
                end
            end
            default: drive_next = STOP;
        endcase
    end

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            op_mode     <= IDLE;
            cam_state   <= PAUSE;
            drive_state <= STOP;
            mode_change <= 1'b0;
        end else begin
            op_mode     <= mode_next;
            cam_state   <= cam_next;
            drive_state <= drive_next;
            mode_change <= (mode_next != op_mode) || (cam_next != cam_state);
        end
    end

endmodule

//--- mode_fsm/status_display.sv
`timescale 1ns/100ps

module status_display
    import robot_pkg::*;
(
    input  op_mode_t     op_mode,
    input  cam_state_t   cam_state,
    input  drive_state_t drive_state,
    output logic [6:0]   hex0,
    output logic [6:0]   hex1,
    output logic [6:0]   hex2,
    output logic [6:0]   hex3,
    output logic [6:0]   hex4,
    output logic [6:0]   hex5,
    output logic [6:0]   hex6,
    output logic [6:0]   hex7
);

    // Active low, bit 6 is segment g
    localparam logic [6:0] SEG_BLANK = 7'b1111111;
    localparam logic [6:0] SEG_A = 7'b0001000;
    localparam logic [6:0] SEG_C = 7'b1000110;
    localparam logic [6:0] SEG_D = 7'b0100001;   // Lower case d
    localparam logic [6:0] SEG_E = 7'b0000110;
    localparam logic [6:0] SEG_F = 7'b0001110;
    localparam logic [6:0] SEG_G = 7'b0000010;
    localparam logic [6:0] SEG_H = 7'b0001001;
    localparam logic [6:0] SEG_I = 7'b1111001;
    localparam logic [6:0] SEG_L = 7'b1000111;
    localparam logic [6:0] SEG_O = 7'b1000000;
    localparam logic [6:0] SEG_P = 7'b0001100;
    localparam logic [6:0] SEG_R = 7'b0101111;   // Lower case r
    localparam logic [6:0] SEG_S = 7'b0010010;
    localparam logic [6:0] SEG_T = 7'b0001111;   // Lower case t
    localparam logic [6:0] SEG_1 = 7'b1111001;
    localparam logic [6:0] SEG_2 = 7'b0100100;
    localparam logic [6:0] SEG_3 = 7'b0110000;

    assign hex5 = SEG_BLANK;

    always_comb begin
        case (op_mode)
            IDLE:    {hex7, hex6} = {SEG_I, SEG_D};
            CAM:     {hex7, hex6} = {SEG_C, SEG_A};
            IR:      {hex7, hex6} = {SEG_I, SEG_R};
            default: {hex7, hex6} = {SEG_BLANK, SEG_BLANK};
        endcase

        case (cam_state)
            SEARCH:  hex4 = SEG_S;
            FOLLOW:  hex4 = SEG_F;
            PAUSE:   hex4 = SEG_P;
            default: hex4 = SEG_BLANK;
        endcase

        case (drive_state)
            LEFT:    {hex3, hex2, hex1, hex0} = {SEG_L, SEG_E, SEG_F, SEG_T};
            RIGHT:   {hex3, hex2, hex1, hex0} = {SEG_R, SEG_G, SEG_H, SEG_T};
            STOP:    {hex3, hex2, hex1, hex0} = {SEG_S, SEG_T, SEG_O, SEG_P};
            SLOW:    {hex3, hex2, hex1, hex0} = {SEG_S, SEG_P, SEG_BLANK, SEG_1};
            MEDIUM:  {hex3, hex2, hex1, hex0} = {SEG_S, SEG_P, SEG_BLANK, SEG_2};
            FAST:    {hex3, hex2, hex1, hex0} = {SEG_S, SEG_P, SEG_BLANK, SEG_3};
            default: {hex3, hex2, hex1, hex0} = {4{SEG_BLANK}};
        endcase
    end

endmodule

//--- sim/robot_ctrl_tb.sv
`timescale 1ns/100ps
`include "robot_cfg.svh"

module robot_ctrl_tb
    import robot_pkg::*;
();

    localparam int FRAME_COUNT = 66;    // Frames sent with the camera sweep counted as four
    localparam int WATCHDOG_CYCLES = FRAME_COUNT * 20 + 200;

    // Display characters and their active-low patterns in matching order
    localparam logic [8*18-1:0] GLYPH_CHARS = "AdCEFGHILOPrSt123 ";
    localparam logic [7*18-1:0] GLYPH_CODES = {7'h08, 7'h21, 7'h46, 7'h06, 7'h0e, 7'h02,
        7'h09, 7'h79, 7'h47, 7'h40, 7'h0c, 7'h2f, 7'h12, 7'h0f, 7'h79, 7'h24, 7'h30, 7'h7f};

    // Remote keys for IR mode with the first key in the top byte
    localparam logic [71:0] IR_SEQ = {`KEY_LEFT, 8'h55, `KEY_RIGHT, 8'h20, `KEY_SLOW,
        `KEY_MEDIUM, 8'h7e, `KEY_FAST, `KEY_STOP};

    logic         clk_50 = 1'b0;
    logic         rst_n = 1'b0;
    logic         ir_bit = 1'b0, ir_bit_valid = 1'b0, ir_frame_start = 1'b0;
    logic [2:0]   cam_direction = 3'd0;
    logic [1:0]   cam_speed = 2'd0;
    logic         orange_detected = 1'b0;
    op_mode_t     op_mode;
    cam_state_t   cam_state;
    drive_state_t drive_state;
    logic         mode_change, key_overflow;
    logic [6:0]   hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7;
    logic [55:0]  hex_word;

    op_mode_t     mdl_mode = IDLE;      // Expected state after the last step
    cam_state_t   mdl_cam = PAUSE;
    drive_state_t mdl_drive = STOP;
    logic         exp_mchg = 1'b0;
    logic [31:0]  rng = 32'h793;
    logic [7:0]   rnd_key;
    string        test_name = "reset";
    event         check_ev;
    int           checks_done = 0;

    robot_ctrl_top i_robot_ctrl_top (.*);

    assign hex_word = {hex7, hex6, hex5, hex4, hex3, hex2, hex1, hex0};

    always #50 clk_50 = ~clk_50;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [6:0] glyph(input logic [7:0] ch);
        for (int i = 0; i < 18; i++) begin
            if (GLYPH_CHARS[8*i +: 8] == ch) return GLYPH_CODES[7*i +: 7];
        end
        return 7'h7f;
    endfunction

    // Expected {hex7..hex0} for a state triple
    function automatic logic [55:0] display_word(input op_mode_t m, input cam_state_t c,
                                                 input drive_state_t d);
        logic [63:0] txt;
        logic [55:0] w;
        txt[63:48] = (m == IDLE) ? "Id" : (m == CAM) ? "CA" : "Ir";
        txt[47:40] = " ";
        txt[39:32] = (c == SEARCH) ? "S" : (c == FOLLOW) ? "F" : "P";
        txt[31:0]  = (d == LEFT) ? "LEFt" : (d == RIGHT) ? "rGHt" : (d == SLOW) ? "SP 1" :
                     (d == MEDIUM) ? "SP 2" : (d == FAST) ? "SP 3" : "StOP";
        for (int i = 0; i < 8; i++) begin
            w[7*i +: 7] = glyph(txt[8*i +: 8]);
        end
        return w;
    endfunction

    // Next {mode, camera state, drive} for one clock with an optional key
    function automatic logic [6:0] ref_step(input op_mode_t m, input cam_state_t c,
        input drive_state_t d, input logic kv, input logic [7:0] k, input logic orange,
        input logic [2:0] dir, input logic [1:0] spd);
        op_mode_t     nm;
        cam_state_t   nc;
        drive_state_t nd;
        nm = !kv ? m : (k == `KEY_CAM) ? CAM : (k == `KEY_IR) ? IR :
             (k == `KEY_IDLE) ? IDLE : m;
        nc = (nm != CAM) ? PAUSE : (c == PAUSE || !orange) ? SEARCH : FOLLOW;
        nd = STOP;
        if (nm == CAM) begin
            if (nc == SEARCH || dir == `CAM_DIR_RIGHT) begin
                nd = RIGHT;
            end else if (dir == `CAM_DIR_LEFT) begin
                nd = LEFT;
            end else if (dir == `CAM_DIR_AHEAD) begin
                nd = (spd == 2'd0) ? SLOW : (spd == 2'd1) ? MEDIUM : (spd == 2'd2) ? FAST : STOP;
            end
        end else if (nm == IR && m == IR) begin
            nd = d;                                     // Held until a drive key
            if (kv) begin
                case (k)
                    `KEY_STOP:   nd = STOP;
                    `KEY_LEFT:   nd = LEFT;
                    `KEY_RIGHT:  nd = RIGHT;
                    `KEY_SLOW:   nd = SLOW;
                    `KEY_MEDIUM: nd = MEDIUM;
                    `KEY_FAST:   nd = FAST;
                    default:     nd = d;
                endcase
            end
        end
        return {nm, nc, nd};
    endfunction

    task automatic model_step(input logic kv, input logic [7:0] k);
        logic [6:0] nxt;
        nxt = ref_step(mdl_mode, mdl_cam, mdl_drive, kv, k, orange_detected, cam_direction,
                       cam_speed);
        exp_mchg  = (nxt[6:5] != mdl_mode) || (nxt[4:3] != mdl_cam);
        mdl_mode  = op_mode_t'(nxt[6:5]);
        mdl_cam   = cam_state_t'(nxt[4:3]);
        mdl_drive = drive_state_t'(nxt[2:0]);
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        $display("Mismatch in %s on %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
        $display("Test failed");
        $fatal(1, "Stopping at first error");
    endtask

    // Compare at the falling edge and wait until the comparison has run
    task automatic run_check();
        int done_before;
        done_before = checks_done;
        @(negedge clk_50);
        -> check_ev;
        wait (checks_done != done_before);
    endtask

    // Frames back to back and then the key to state latency before the check
    task automatic send_frames(input logic [7:0] k, input logic [7:0] chk, input int count);
        logic [15:0] frame;
        frame = {k, chk};
        for (int f = 0; f < count; f++) begin
            for (int i = 15; i >= 0; i--) begin
                @(posedge clk_50);
                #5;
                ir_bit_valid   = 1'b1;
                ir_frame_start = (i == 15);
                ir_bit         = frame[i];             // MSB first
                assert (key_overflow === 1'b0)
                    else report_mismatch("key_overflow", 64'd0, key_overflow);
            end
            model_step(chk == ~k, k);
        end
        @(posedge clk_50);
        #5;
        ir_bit_valid   = 1'b0;
        ir_frame_start = 1'b0;
        repeat (2) @(posedge clk_50);
        run_check();
    endtask

    task automatic send_key(input logic [7:0] k);
        send_frames(k, ~k, 1);
    endtask

    always @(check_ev) begin
        assert (op_mode === mdl_mode) else report_mismatch("op_mode", mdl_mode, op_mode);
        assert (cam_state === mdl_cam) else report_mismatch("cam_state", mdl_cam, cam_state);
        assert (drive_state === mdl_drive)
            else report_mismatch("drive_state", mdl_drive, drive_state);
        assert (mode_change === exp_mchg)
            else report_mismatch("mode_change", exp_mchg, mode_change);
        assert (key_overflow === 1'b0) else report_mismatch("key_overflow", 64'd0, key_overflow);
        assert (hex_word === display_word(mdl_mode, mdl_cam, mdl_drive))
            else report_mismatch("hex7..hex0", display_word(mdl_mode, mdl_cam, mdl_drive),
                                 hex_word);
        checks_done = checks_done + 1;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_50);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        repeat (2) @(posedge clk_50);
        #5;
        rst_n = 1'b1;
        run_check();

        test_name = "bad_check";
        send_frames(`KEY_CAM, 8'h00, 1);               // Check byte not the complement
        send_key(`KEY_CAM);

        test_name = "random_keys";
        repeat (40) begin
            rng = xorshift(rng);
            rnd_key = (rng[1:0] == 2'd0) ? `KEY_CAM : (rng[1:0] == 2'd1) ? `KEY_IR :
                      (rng[1:0] == 2'd2) ? `KEY_IDLE : rng[15:8];
            send_key(rnd_key);
        end

        test_name = "ir_drive";
        send_key(`KEY_IR);
        for (int i = 8; i >= 0; i--) begin
            send_key(IR_SEQ[8*i +: 8]);
        end

        // Orange toggles innermost so SEARCH and FOLLOW alternate
        test_name = "cam_sweep";
        send_key(`KEY_CAM);
        for (int d = 0; d < 4; d++) begin
            for (int s = 0; s < 4; s++) begin
                for (int o = 0; o < 2; o++) begin
                    @(posedge clk_50);
                    #5;
                    cam_direction   = 3'(d);
                    cam_speed       = 2'(s);
                    orange_detected = o[0];
                    model_step(1'b0, 8'h00);
                    @(posedge clk_50);
                    run_check();
                end
            end
        end
        test_name = "leave_cam";
        send_key(`KEY_IR);

        test_name = "burst";
        send_frames(`KEY_IDLE, ~`KEY_IDLE, 8);

        $display("Test passed");
        $finish;
    end

endmodule

//--- source/ir_frame_rx.sv
`timescale 1ns/100ps
`include "robot_cfg.svh"

module ir_frame_rx (
    input  logic       clk_50,
    input  logic       rst_n,
    input  logic       ir_bit,
    input  logic       ir_bit_valid,
    input  logic       ir_frame_start,
    output logic       key_push,
    output logic [7:0] key_code
);

    localparam int FRAME_BITS = `IR_FRAME_BITS;
    localparam int CNT_W      = $clog2(FRAME_BITS + 1);

    logic [FRAME_BITS-1:0] shift_q;
    logic [FRAME_BITS-1:0] shift_next;
    logic [CNT_W-1:0]      bit_cnt;
    logic [CNT_W-1:0]      cnt_base;
    logic                  shift_en;
    logic                  last_bit;
    logic                  frame_ok;

    assign cnt_base   = ir_frame_start ? '0 : bit_cnt;           // Start bit may share the cycle
    assign shift_en   = ir_bit_valid && (cnt_base != CNT_W'(FRAME_BITS));
    assign shift_next = {shift_q[FRAME_BITS-2:0], ir_bit};      // MSB first
    assign last_bit   = shift_en && (cnt_base == CNT_W'(FRAME_BITS - 1));
    assign frame_ok   = (shift_next[FRAME_BITS-1 -: 8] == ~shift_next[7:0]);

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt  <= '0;
            key_push <= 1'b0;
        end else begin
            key_push <= last_bit && frame_ok;                    // Bad check byte drops frame
            if (shift_en) begin
                bit_cnt <= cnt_base + 1'b1;
            end else begin
                bit_cnt <= cnt_base;                             // Saturates when full
            end
        end
    end

    always_ff @(posedge clk_50) begin
        if (shift_en) begin
            shift_q <= shift_next;
        end
        if (last_bit) begin
            key_code <= shift_next[FRAME_BITS-1 -: 8];           // Key byte
        end
    end

    // A full frame must be followed by a new frame start before more bits
    a_no_bit_when_full: assert property (@(posedge clk_50) disable iff (!rst_n)
        ir_bit_valid && !ir_frame_start |-> bit_cnt != CNT_W'(FRAME_BITS))
        else $error("IR bit received with frame counter full");

endmodule

//--- source/key_fifo.sv
`timescale 1ns/100ps
`include "robot_cfg.svh"

module key_fifo (
    input  logic       clk_50,
    input  logic       rst_n,
    input  logic       key_push,
    input  logic [7:0] key_code,
    input  logic       key_pop,
    output logic [7:0] key_head,
    output logic       key_empty,
    output logic       key_overflow
);

    localparam int DEPTH = `KEY_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign full      = (count == (AW+1)'(DEPTH));
    assign key_empty = (count == '0);
    assign do_push   = key_push && !full;           // Push into full store is lost
    assign do_pop    = key_pop && !key_empty;
    assign key_head  = mem[rd_ptr];                 // Show-ahead

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            key_overflow <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (key_push && full) key_overflow <= 1'b1;  // Sticky until reset
        end
    end

    always_ff @(posedge clk_50) begin
        if (do_push) mem[wr_ptr] <= key_code;
    end

    a_no_pop_empty: assert property (@(posedge clk_50) disable iff (!rst_n)
        key_pop |-> !key_empty) else $error("Key popped from empty FIFO");

    a_count_bound: assert property (@(posedge clk_50) disable iff (!rst_n)
        count <= (AW+1)'(DEPTH)) else $error("Key FIFO count above depth");

endmodule

//--- source/robot_ctrl_top.sv
`timescale 1ns/100ps

module robot_ctrl_top
    import robot_pkg::*;
(
    input  logic         clk_50,
    input  logic         rst_n,
    input  logic         ir_bit,
    input  logic         ir_bit_valid,
    input  logic         ir_frame_start,
    input  logic [2:0]   cam_direction,
    input  logic [1:0]   cam_speed,
    input  logic         orange_detected,
    output op_mode_t     op_mode,
    output cam_state_t   cam_state,
    output drive_state_t drive_state,
    output logic         mode_change,
    output logic         key_overflow,
    output logic [6:0]   hex0,
    output logic [6:0]   hex1,
    output logic [6:0]   hex2,
    output logic [6:0]   hex3,
    output logic [6:0]   hex4,
    output logic [6:0]   hex5,
    output logic [6:0]   hex6,
    output logic [6:0]   hex7
);

    logic       key_push;
    logic [7:0] key_code;
    logic       key_pop;
    logic [7:0] key_head;
    logic       key_empty;

    ir_frame_rx i_ir_frame_rx (
        .clk_50, .rst_n, .ir_bit, .ir_bit_valid, .ir_frame_start, .key_push, .key_code
    );

    key_fifo i_key_fifo (
        .clk_50, .rst_n, .key_push, .key_code, .key_pop, .key_head, .key_empty, .key_overflow
    );

    mode_fsm i_mode_fsm (
        .clk_50, .rst_n, .key_head, .key_empty, .cam_direction, .cam_speed,
        .orange_detected, .key_pop, .op_mode, .cam_state, .drive_state, .mode_change
    );

    status_display i_status_display (
        .op_mode, .cam_state, .drive_state,
        .hex0, .hex1, .hex2, .hex3, .hex4, .hex5, .hex6, .hex7
    );

endmodule
